//--- wb_pkg.sv
package wb_pkg;

  // word address, byte lane 0 is implied by sel
  typedef logic [20:1] wb_adr_t;
  typedef logic [15:0] wb_dat_t;
  typedef logic [1:0]  wb_sel_t;

  // master request, fields in bus order
  typedef struct packed {
    wb_adr_t adr;
    wb_sel_t sel;
    wb_dat_t dat;
    logic    we;
    logic    cyc;
    logic    stb;
  } wb_req_t;

  // slave response
  typedef struct packed {
    wb_dat_t dat;
    logic    ack;
  } wb_rsp_t;

  // address map, word addresses
  // ram covers the lowest 256 words
  localparam wb_adr_t RAM_ADDR  = 20'h00000;
  localparam wb_adr_t RAM_MASK  = 20'hFFF00;

  // fifo mailbox, data word then status word
  localparam wb_adr_t FIFO_ADDR = 20'h08000;
  localparam wb_adr_t FIFO_MASK = 20'hFFFFE;

  // ram geometry
  localparam int unsigned RAM_AW = 8;

  // fifo geometry, depth must be a power of two
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned FIFO_PW    = 3;

  // ram, fifo, gpio
  localparam int unsigned NUM_SLAVES = 3;

endpackage

//--- wb_switch.sv
`timescale 1ns/1ns

module wb_switch (
  // master side
  input  wb_pkg::wb_req_t m_req_i,
  output wb_pkg::wb_rsp_t m_rsp_o,

  // ram slave
  output wb_pkg::wb_req_t ram_req_o,
  input  wb_pkg::wb_rsp_t ram_rsp_i,

  // fifo mailbox slave
  output wb_pkg::wb_req_t fifo_req_o,
  input  wb_pkg::wb_rsp_t fifo_rsp_i,

  // gpio slave, takes every unmatched address
  output wb_pkg::wb_req_t gpio_req_o,
  input  wb_pkg::wb_rsp_t gpio_rsp_i
);

  import wb_pkg::*;

  logic [NUM_SLAVES-1:0] slave_sel;
  logic                  bus_stb;
  wb_req_t               slv_req [NUM_SLAVES];
  wb_rsp_t               slv_rsp [NUM_SLAVES];

  // slot order: 0 ram, 1 fifo, 2 gpio
  assign slv_rsp[0] = ram_rsp_i;
  assign slv_rsp[1] = fifo_rsp_i;
  assign slv_rsp[2] = gpio_rsp_i;

  // priority decode, earlier slots win
  assign slave_sel[0] = ((m_req_i.adr & RAM_MASK) == RAM_ADDR);
  assign slave_sel[1] = ((m_req_i.adr & FIFO_MASK) == FIFO_ADDR)
                      & ~slave_sel[0];

  // default slave catches the rest
  assign slave_sel[2] = ~(|slave_sel[1:0]);

  assign bus_stb = m_req_i.cyc & m_req_i.stb;

  // all slaves see the master fields, only the selected one sees stb
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      slv_req[i]     = m_req_i;
      slv_req[i].stb = bus_stb & slave_sel[i];
    end
  end

  assign ram_req_o  = slv_req[0];
  assign fifo_req_o = slv_req[1];
  assign gpio_req_o = slv_req[2];

  // ack is a plain OR, data is gated by the select
  always_comb begin
    m_rsp_o = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      m_rsp_o.ack = m_rsp_o.ack | slv_rsp[i].ack;
      m_rsp_o.dat = m_rsp_o.dat
                  | ({$bits(wb_dat_t){slave_sel[i]}} & slv_rsp[i].dat);
    end
  end

endmodule

//--- wb_ram.sv
`timescale 1ns/1ns

module wb_ram (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  import wb_pkg::*;

  wb_dat_t           mem_q [2**RAM_AW];
  wb_dat_t           rdat_q;
  logic              ack_q;
  logic              acc;
  logic [RAM_AW-1:0] idx;

  // new access only while no ack is pending
  assign acc = req_i.cyc & req_i.stb & ~ack_q;
  assign idx = req_i.adr[RAM_AW:1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
    end
  end

  // byte lanes written only where sel is set
  always_ff @(posedge clk_i) begin
    if (acc && req_i.we) begin
      for (int b = 0; b < $bits(wb_sel_t); b++) begin
        if (req_i.sel[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
  end

  // read word lands together with ack
  always_ff @(posedge clk_i) begin
    if (acc && !req_i.we) begin
      rdat_q <= mem_q[idx];
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

endmodule

//--- wb_fifo_mbox.sv
`timescale 1ns/1ns

module wb_fifo_mbox (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  import wb_pkg::*;

  wb_dat_t            mem_q [FIFO_DEPTH];
  logic [FIFO_PW-1:0] wr_ptr_q;
  logic [FIFO_PW-1:0] rd_ptr_q;
  logic [FIFO_PW:0]   count_q;
  logic               ovf_q;
  logic               ack_q;
  wb_dat_t            rdat_q;
  wb_dat_t            status;
  logic               acc;
  logic               sel_stat;
  logic               empty;
  logic               full;
  logic               push;
  logic               pop;

  assign acc      = req_i.cyc & req_i.stb & ~ack_q;
  // adr bit 1 picks status over data
  assign sel_stat = req_i.adr[1];

  assign empty = (count_q == '0);
  assign full  = (count_q == (FIFO_PW+1)'(FIFO_DEPTH));

  // push dropped when full, pop ignored when empty
  assign push = acc & req_i.we & ~sel_stat & ~full;
  assign pop  = acc & ~req_i.we & ~sel_stat & ~empty;

  // status layout: count 3..0, empty 8, full 9, overflow 10
  always_comb begin
    status             = '0;
    status[FIFO_PW:0]  = count_q;
    status[8]          = empty;
    status[9]          = full;
    status[10]         = ovf_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ovf_q    <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= acc;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      // sticky until software clears it
      if (acc && req_i.we && !sel_stat && full) begin
        ovf_q <= 1'b1;
      end else if (acc && req_i.we && sel_stat && req_i.dat[10]) begin
        ovf_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_i.dat;
    end
  end

  // empty fifo reads as zero
  always_ff @(posedge clk_i) begin
    if (acc && !req_i.we) begin
      if (sel_stat) begin
        rdat_q <= status;
      end else if (empty) begin
        rdat_q <= '0;
      end else begin
        rdat_q <= mem_q[rd_ptr_q];
      end
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

endmodule

//--- wb_gpio.sv
`timescale 1ns/1ns

module wb_gpio (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o,
  input  wb_pkg::wb_dat_t gpio_i,
  output wb_pkg::wb_dat_t gpio_o
);

  import wb_pkg::*;

  wb_dat_t out_q;
  wb_dat_t in_meta_q;
  wb_dat_t in_sync_q;
  wb_dat_t rdat_q;
  logic    ack_q;
  logic    acc;
  logic    sel_in;

  assign acc    = req_i.cyc & req_i.stb & ~ack_q;
  // only adr bit 1 is decoded, everything else aliases
  assign sel_in = req_i.adr[1];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc;
      if (acc && req_i.we && !sel_in) begin
        for (int b = 0; b < $bits(wb_sel_t); b++) begin
          if (req_i.sel[b]) begin
            out_q[8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  // two flop synchronizer on the inputs
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_i;
    in_sync_q <= in_meta_q;
  end

  // writes to the input word are ignored
  always_ff @(posedge clk_i) begin
    if (acc && !req_i.we) begin
      rdat_q <= sel_in ? in_sync_q : out_q;
    end
  end

  assign gpio_o    = out_q;
  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

endmodule

//--- wb_subsys.sv
`timescale 1ns/1ns

module wb_subsys (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // master port
  input  wb_pkg::wb_req_t m_req_i,
  output wb_pkg::wb_rsp_t m_rsp_o,

  // gpio pins
  input  wb_pkg::wb_dat_t gpio_i,
  output wb_pkg::wb_dat_t gpio_o
);

  import wb_pkg::*;

  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t fifo_req;
  wb_rsp_t fifo_rsp;
  wb_req_t gpio_req;
  wb_rsp_t gpio_rsp;

  // address decode and response mux
  wb_switch u_wb_switch (
    .m_req_i    (m_req_i),
    .m_rsp_o    (m_rsp_o),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .fifo_req_o (fifo_req),
    .fifo_rsp_i (fifo_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  wb_ram u_wb_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

  // mailbox between bus writers and readers
  wb_fifo_mbox u_wb_fifo_mbox (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (fifo_req),
    .rsp_o   (fifo_rsp)
  );

  // default slave
  wb_gpio u_wb_gpio (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (gpio_req),
    .rsp_o   (gpio_rsp),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o)
  );

endmodule

//--- tb_wb_subsys.sv
`timescale 1ns/1ns

module tb_wb_subsys;

  import wb_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int DRIVE_DELAY  = 2;
  localparam int SAMPLE_DELAY = 1;
  // cycles allowed per trace line before the watchdog fires
  localparam int LINE_CYCLES  = 8;

  // one parsed trace line
  typedef struct packed {
    logic [7:0] op;
    wb_adr_t    adr;
    wb_sel_t    sel;
    wb_dat_t    dat;
    wb_dat_t    exp;
  } trace_entry_t;

  logic         clk;
  logic         rst_n;
  wb_req_t      m_req;
  wb_rsp_t      m_rsp;
  wb_dat_t      gpio_in;
  wb_dat_t      gpio_out;

  trace_entry_t trace_q [$];
  logic [31:0]  lfsr;
  bit           trace_loaded;
  int           lines_done;

  wb_subsys u_wb_subsys (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .m_req_i (m_req),
    .m_rsp_o (m_rsp),
    .gpio_i  (gpio_in),
    .gpio_o  (gpio_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, exp);
      stop_on_failure();
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 0 to 3 idle cycles from two lfsr steps
  task automatic idle_gap();
    int gap;
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      gap  = (gap << 1) | lfsr[0];
    end
    repeat (gap) @(posedge clk);
  endtask

  task automatic load_trace();
    int               fd;
    int               code;
    logic [7:0]       op_ch;
    logic [19:0]      adr;
    logic [1:0]       sel;
    logic [15:0]      dat;
    logic [15:0]      exp;
    logic [8*128-1:0] skip;
    trace_entry_t     ent;
    fd = $fopen("wb_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file wb_trace.txt");
      stop_on_failure();
    end
    code = $fscanf(fd, " %c", op_ch);
    while (code == 1) begin
      if (op_ch == "#") begin
        code = $fgets(skip, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h", adr, sel, dat, exp);
        if (code != 4) begin
          $display("trace entry %0d is malformed", trace_q.size() + 1);
          stop_on_failure();
        end
        ent.op  = op_ch;
        ent.adr = adr;
        ent.sel = sel;
        ent.dat = dat;
        ent.exp = exp;
        trace_q.push_back(ent);
      end
      code = $fscanf(fd, " %c", op_ch);
    end
    $fclose(fd);
  endtask

  // one classic cycle held until ack
  task automatic bus_access(input trace_entry_t ent);
    int cycles;
    @(posedge clk);
    #DRIVE_DELAY;
    m_req.adr = ent.adr;
    m_req.sel = ent.sel;
    m_req.we  = (ent.op == "W");
    m_req.dat = (ent.op == "W") ? ent.dat : '0;
    m_req.cyc = 1'b1;
    m_req.stb = 1'b1;
    #SAMPLE_DELAY;
    cycles = 0;
    while (!m_rsp.ack) begin
      @(posedge clk);
      #SAMPLE_DELAY;
      cycles++;
    end
    expect_equal("ack latency in cycles", cycles, 1);
    if (ent.op == "R") begin
      expect_equal("m_rsp_o.dat", m_rsp.dat, ent.exp);
    end else begin
      expect_equal("gpio_o", gpio_out, ent.exp);
    end
    #(DRIVE_DELAY - SAMPLE_DELAY);
    m_req = '0;
    // ack must not repeat
    @(posedge clk);
    #SAMPLE_DELAY;
    expect_equal("m_rsp_o.ack", m_rsp.ack, 0);
  endtask

  task automatic set_gpio_in(input wb_dat_t value);
    @(posedge clk);
    #DRIVE_DELAY;
    gpio_in = value;
    // let it pass both synchronizer stages
    repeat (2) @(posedge clk);
  endtask

  initial begin
    m_req        = '0;
    gpio_in      = '0;
    rst_n        = 1'b0;
    lfsr         = 32'h92443229;
    trace_loaded = 1'b0;
    lines_done   = 0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    expect_equal("m_rsp_o.ack", m_rsp.ack, 0);
    expect_equal("gpio_o", gpio_out, 0);
    foreach (trace_q[i]) begin
      idle_gap();
      case (trace_q[i].op)
        "W", "R": bus_access(trace_q[i]);
        "G": set_gpio_in(trace_q[i].dat);
        default: begin
          $display("unknown operation in trace entry %0d", i + 1);
          stop_on_failure();
        end
      endcase
      lines_done++;
    end
    if (lines_done > 0 && lines_done == trace_q.size()) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("the trace file held no operations");
      stop_on_failure();
    end
  end

  // watchdog sized from the trace length
  initial begin
    wait (trace_loaded);
    repeat (trace_q.size() * LINE_CYCLES + RESET_CYCLES + 1) @(posedge clk);
    $display("timeout: the bus handshake hung, the trace did not finish in time");
    stop_on_failure();
  end

endmodule

//--- wb_trace.txt
# columns: op adr sel dat exp, hex; adr is the word address
# op W write (exp = gpio_o after), R read (exp = read data), G set gpio_i to dat
# ram full words and byte merges
W 00000 3 a5a5 0000
W 00010 3 1234 0000
W 000ff 3 beef 0000
R 00000 3 0000 a5a5
R 00010 3 0000 1234
R 000ff 3 0000 beef
W 00010 1 9956 0000
W 000ff 2 caff 0000
R 00010 3 0000 1256
R 000ff 3 0000 caef
# unmatched addresses reach gpio and alias by adr bit 1
W 00110 3 00ff 00ff
R 00010 3 0000 1256
W 40002 2 8177 81ff
R fffe0 3 0000 81ff
W 00101 3 ffff 81ff
G 00000 0 3c5a 0000
R 00101 3 0000 3c5a
R 08003 3 0000 3c5a
# fifo order and status
R 08001 3 0000 0100
W 08000 3 1111 81ff
R 08001 3 0000 0001
W 08000 3 2222 81ff
W 08000 3 3333 81ff
R 08001 3 0000 0003
R 08000 3 0000 1111
R 08001 3 0000 0002
W 08000 3 4444 81ff
W 08000 3 5555 81ff
W 08000 3 6666 81ff
W 08000 3 7777 81ff
W 08000 3 8888 81ff
W 08000 3 9999 81ff
R 08001 3 0000 0208
# ninth push, overflow, drain, clear
W 08000 3 aaaa 81ff
R 08001 3 0000 0608
W 08001 3 0000 81ff
R 08000 3 0000 2222
R 08001 3 0000 0407
R 08000 3 0000 3333
R 08000 3 0000 4444
R 08000 3 0000 5555
R 08000 3 0000 6666
R 08000 3 0000 7777
R 08000 3 0000 8888
R 08000 3 0000 9999
R 08000 3 0000 0000
R 08001 3 0000 0500
W 08001 3 0400 81ff
R 08001 3 0000 0100

//--- vlog.f
wb_pkg.sv
wb_switch.sv
wb_ram.sv
wb_fifo_mbox.sv
wb_gpio.sv
wb_subsys.sv
tb_wb_subsys.sv

//--- Bender.yml
package:
  name: wb_subsys

sources:
  - wb_pkg.sv
  - wb_switch.sv
  - wb_ram.sv
  - wb_fifo_mbox.sv
  - wb_gpio.sv
  - wb_subsys.sv
  - target: simulation
    files:
      - tb_wb_subsys.sv
